// ==== src.f ====
hw/mcs_pkg.sv
hw/core_if.sv
hw/task_memory.sv
hw/task_scheduler.sv
hw/compute_core.sv
hw/frame_sync.sv
hw/mcs_top.sv
tb/mcs_tb.sv

// ==== Bender.yml ====
package:
  name: mcs_cluster

sources:
  - files:
      - hw/mcs_pkg.sv
      - hw/core_if.sv
      - hw/task_memory.sv
      - hw/task_scheduler.sv
      - hw/compute_core.sv
      - hw/frame_sync.sv
      - hw/mcs_top.sv
  - target: test
    files:
      - tb/mcs_tb.sv

// ==== tb/mcs_tb.sv ====
module mcs_tb;
	import mcs_pkg::*;

	localparam int frame_period   = 64;   // mcs_top default
	localparam int reset_cycles   = 10;
	localparam int prog_len       = 8;
	localparam int num_stops      = 2;    // Snapshots expected before the end
	localparam int timeout_cycles = 4 * frame_period * num_stops + 2000;
	localparam int seed           = 43397;
	localparam int loop_addr      = 2;
	localparam logic [num_cores-1:0] mask_b = 4'b0011;
	localparam logic [num_cores-1:0] mask_c = 4'b1100;

	logic                       clk;
	logic                       reset;
	logic                       tm_we;
	logic [addr_w-1:0]          tm_addr;
	logic [word_w-1:0]          tm_wdata;
	logic [num_cores*reg_w-1:0] core_r0;
	logic [num_cores*reg_w-1:0] snapshot;
	logic                       snapshot_valid;

	logic [word_w-1:0]          prog [prog_len];
	insn_frame_t                frames [5];
	logic [reg_w-1:0]           init_val [num_cores];
	logic [reg_w-1:0]           model_r0 [num_cores];
	logic [num_cores*reg_w-1:0] exp_snap [num_stops];
	logic [num_cores*reg_w-1:0] held_snap;
	int                         snap_count;

	mcs_top i_mcs_top (
		.clk            (clk),
		.reset          (reset),
		.tm_we          (tm_we),
		.tm_addr        (tm_addr),
		.tm_wdata       (tm_wdata),
		.core_r0        (core_r0),
		.snapshot       (snapshot),
		.snapshot_valid (snapshot_valid)
	);

	always #20 clk = ~clk;

	function automatic logic [parcel_w-1:0] make_parcel(input opcode_t op,
		input logic [reg_w-1:0] imm);
		return {op, imm, 4'h0};
	endfunction

	function automatic opcode_t random_op();
		return opcode_t'(4'($urandom_range(4)));
	endfunction

	// One step of a core, straight from the opcode rules
	function automatic logic [reg_w-1:0] apply_parcel(input logic [reg_w-1:0] r,
		input logic [parcel_w-1:0] p);
		logic [reg_w-1:0] imm;
		imm = p[11:4];
		case (opcode_t'(p[15:12]))
			op_add:  return r + imm;
			op_sub:  return r - imm;
			op_xor:  return r ^ imm;
			op_shl:  return r << imm[2:0];
			default: return r;
		endcase
	endfunction

	task automatic apply_frame(input insn_frame_t f, input logic [num_cores-1:0] mask);
		for (int c = 0; c < num_cores; c++) begin
			if (mask[c]) begin
				for (int p = 0; p < parcels_per_frame; p++) begin
					model_r0[c] = apply_parcel(model_r0[c], f[p]);
				end
			end
		end
	endtask

	task automatic build_program();
		ctrl_frame_t c;
		opcode_t     f1_ops [parcels_per_frame];
		f1_ops = '{op_add, op_sub, op_xor, op_shl};
		for (int i = 0; i < num_cores; i++) begin
			init_val[i] = reg_w'($urandom);
		end
		for (int p = 0; p < parcels_per_frame; p++) begin
			frames[0][p] = make_parcel(f1_ops[p], reg_w'($urandom));
		end
		for (int k = 1; k < 5; k++) begin
			for (int p = 0; p < parcels_per_frame; p++) begin
				frames[k][p] = make_parcel(random_op(), reg_w'($urandom));
			end
		end
		frames[1][0] = make_parcel(op_nop, reg_w'($urandom));   // Sure nop coverage

		c = '0;
		c.insn_frame_num = 1;
		c.core_active    = '1;
		c.init_r0_vect   = '1;
		c.fence          = fence_no;
		for (int i = 0; i < num_cores; i++) begin
			c.init_r0[i] = init_val[i];
		end
		prog[0] = c;
		prog[1] = frames[0];

		c = '0;
		c.insn_frame_num = 3;
		c.core_active    = mask_b;
		c.fence          = fence_acq;   // Loop body starts here
		prog[2] = c;
		prog[3] = frames[1];
		prog[4] = frames[2];
		prog[5] = frames[3];

		c = '0;
		c.insn_frame_num = 1;
		c.core_active    = mask_c;
		c.fence          = fence_rel;
		c.stop           = 1'b1;
		c.stop_addr      = addr_w'(loop_addr);
		prog[6] = c;
		prog[7] = frames[4];
	endtask

	task automatic compute_expected();
		for (int i = 0; i < num_cores; i++) begin
			model_r0[i] = init_val[i];
		end
		apply_frame(frames[0], '1);
		for (int s = 0; s < num_stops; s++) begin
			apply_frame(frames[1], mask_b);
			apply_frame(frames[2], mask_b);
			apply_frame(frames[3], mask_b);
			apply_frame(frames[4], mask_c);
			for (int i = 0; i < num_cores; i++) begin
				exp_snap[s][i*reg_w +: reg_w] = model_r0[i];
			end
		end
	endtask

	task automatic write_word(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data);
		@(posedge clk);
		#2;
		tm_we    = 1'b1;
		tm_addr  = addr;
		tm_wdata = data;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			snap_count <= 0;
		end else if (snapshot_valid) begin
			snap_count <= snap_count + 1;
			held_snap  <= snapshot;
		end
	end

	snap_value: assert property (@(posedge clk) disable iff (reset)
		snapshot_valid && snap_count < num_stops |-> snapshot == exp_snap[snap_count])
	else begin
		$display("FAIL snapshot_pass%0d expected %h actual %h", $sampled(snap_count),
			exp_snap[$sampled(snap_count)], $sampled(snapshot));
		$display("TEST FAIL");
		$fatal(1, "snapshot differs from the model");
	end

	// Cores stay frozen while the display runs
	core_value: assert property (@(posedge clk) disable iff (reset)
		snapshot_valid && snap_count < num_stops |-> core_r0 == exp_snap[snap_count])
	else begin
		$display("FAIL core_r0_pass%0d expected %h actual %h", $sampled(snap_count),
			exp_snap[$sampled(snap_count)], $sampled(core_r0));
		$display("TEST FAIL");
		$fatal(1, "core r0 differs from the model");
	end

	// Display image must hold between captures
	snap_hold: assert property (@(posedge clk) disable iff (reset)
		snap_count != 0 && !snapshot_valid |-> snapshot == held_snap)
	else begin
		$display("FAIL snapshot_hold expected %h actual %h", $sampled(held_snap),
			$sampled(snapshot));
		$display("TEST FAIL");
		$fatal(1, "snapshot changed between pulses");
	end

	snap_pulse: assert property (@(posedge clk) disable iff (reset)
		snapshot_valid |=> !snapshot_valid)
	else begin
		$display("snapshot_valid stayed high for more than one cycle");
		$display("TEST FAIL");
		$fatal(1, "snapshot_valid is not a pulse");
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d snapshots seen",
			timeout_cycles, snap_count, num_stops);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		tm_we    = 1'b0;
		tm_addr  = '0;
		tm_wdata = '0;
		void'($urandom(seed));
		build_program();
		compute_expected();
		for (int a = 0; a < prog_len; a++) begin
			write_word(addr_w'(a), prog[a]);
		end
		@(posedge clk);
		#2;
		tm_we = 1'b0;
		repeat (reset_cycles - prog_len - 1) @(posedge clk);
		#2;
		reset = 1'b0;   // Program runs from address 0
		wait (snap_count == num_stops);
		repeat (2) @(posedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== hw/mcs_top.sv ====
module mcs_top #(
	parameter int tm_depth     = 16,
	parameter int frame_period = 64
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          tm_we,
	input  logic [mcs_pkg::addr_w-1:0]                    tm_addr,
	input  logic [mcs_pkg::word_w-1:0]                    tm_wdata,
	output logic [mcs_pkg::num_cores*mcs_pkg::reg_w-1:0] core_r0,
	output logic [mcs_pkg::num_cores*mcs_pkg::reg_w-1:0] snapshot,
	output logic                                          snapshot_valid
);
	import mcs_pkg::*;

	logic [addr_w-1:0] task_ptr;
	task_word_u        task_word;
	logic              disp_req;
	logic              disp_done;

	core_if cif ();

	task_memory #(
		.tm_depth(tm_depth)
	) i_task_memory (
		.clk   (clk),
		.we    (tm_we),
		.waddr (tm_addr),
		.wdata (tm_wdata),
		.raddr (task_ptr),
		.rdata (task_word)
	);

	task_scheduler i_task_scheduler (
		.clk       (clk),
		.reset     (reset),
		.task_ptr  (task_ptr),
		.task_word (task_word),
		.cores     (cif.sched),
		.disp_req  (disp_req),
		.disp_done (disp_done)
	);

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		compute_core #(
			.core_index(i)
		) i_compute_core (
			.clk   (clk),
			.reset (reset),
			.cif   (cif.core),
			.r0    (core_r0[i*reg_w +: reg_w])
		);
	end

	frame_sync #(
		.frame_period(frame_period)
	) i_frame_sync (
		.clk            (clk),
		.reset          (reset),
		.disp_req       (disp_req),
		.disp_done      (disp_done),
		.core_r0        (core_r0),
		.snapshot       (snapshot),
		.snapshot_valid (snapshot_valid)
	);

endmodule

// ==== hw/frame_sync.sv ====
module frame_sync #(
	parameter int frame_period = 64
) (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic                                               disp_req,
	output logic                                               disp_done,
	input  logic [mcs_pkg::num_cores-1:0][mcs_pkg::reg_w-1:0] core_r0,
	output logic [mcs_pkg::num_cores-1:0][mcs_pkg::reg_w-1:0] snapshot,
	output logic                                               snapshot_valid
);
	import mcs_pkg::*;

	localparam int div_w    = $clog2(frame_period);
	localparam int scan_len = 8;
	localparam int scan_w   = $clog2(scan_len);

	logic [div_w-1:0]  div_cnt;
	logic              boundary;
	logic              capture;
	logic              scan_busy;
	logic [scan_w-1:0] scan_cnt;

	assign boundary = div_cnt == div_w'(frame_period - 1);
	assign capture  = boundary && disp_req && !scan_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= boundary ? '0 : div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			snapshot <= core_r0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			snapshot_valid <= 1'b0;
			scan_busy      <= 1'b0;
			scan_cnt       <= '0;
			disp_done      <= 1'b0;
		end else begin
			snapshot_valid <= capture;
			disp_done      <= 1'b0;
			if (capture) begin
				scan_busy <= 1'b1;
				scan_cnt  <= '0;
			end else if (scan_busy) begin
				scan_cnt <= scan_cnt + 1'b1;
				if (scan_cnt == scan_w'(scan_len - 1)) begin
					scan_busy <= 1'b0;
					disp_done <= 1'b1;   // Scanout finished
				end
			end
		end
	end

endmodule

// ==== hw/compute_core.sv ====
module compute_core #(
	parameter int core_index = 0
) (
	input  logic                      clk,
	input  logic                      reset,
	core_if.core                      cif,
	output logic [mcs_pkg::reg_w-1:0] r0
);
	import mcs_pkg::*;

	insn_frame_t           parcels;
	logic                  ready_q;
	logic [load_cnt_w-1:0] exec_cnt;
	logic                  take;
	logic                  take_last;
	logic [parcel_w-1:0]   cur;
	opcode_t               op;
	logic [reg_w-1:0]      imm;
	logic [reg_w-1:0]      r0_next;

	assign take      = cif.start[core_index];
	assign take_last = take && (cif.load_cnt == load_cnt_w'(parcels_per_frame - 1));

	always_ff @(posedge clk) begin
		if (take) begin
			parcels[cif.load_cnt] <= cif.insn_data;
		end
	end

	assign cur = parcels[exec_cnt];
	assign op  = opcode_t'(cur[parcel_w-1 -: op_w]);
	assign imm = cur[parcel_w-op_w-1 -: reg_w];

	always_comb begin
		case (op)
			op_add:  r0_next = r0 + imm;
			op_sub:  r0_next = r0 - imm;
			op_xor:  r0_next = r0 ^ imm;
			op_shl:  r0_next = r0 << imm[2:0];
			default: r0_next = r0;   // nop and spare codes
		endcase
	end

	// Ready drops once the frame is complete and returns after 4 steps
	always_ff @(posedge clk) begin
		if (reset) begin
			ready_q  <= 1'b1;
			exec_cnt <= '0;
		end else if (take_last) begin
			ready_q  <= 1'b0;
			exec_cnt <= '0;
		end else if (!ready_q) begin
			exec_cnt <= exec_cnt + 1'b1;
			if (exec_cnt == load_cnt_w'(parcels_per_frame - 1)) begin
				ready_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
		end else if (cif.init_r0_vect[core_index]) begin
			r0 <= cif.init_r0[core_index];
		end else if (!ready_q) begin
			r0 <= r0_next;
		end
	end

	assign cif.ready[core_index] = ready_q;

endmodule

// ==== hw/task_scheduler.sv ====
module task_scheduler (
	input  logic                       clk,
	input  logic                       reset,
	output logic [mcs_pkg::addr_w-1:0] task_ptr,
	input  mcs_pkg::task_word_u        task_word,
	core_if.sched                      cores,
	output logic                       disp_req,
	input  logic                       disp_done
);
	import mcs_pkg::*;

	ctrl_frame_t ctrl;
	insn_frame_t insn;

	logic [frame_cnt_w-1:0] frame_cnt;   // Instruction frames still to stream
	logic [num_cores-1:0]   active;
	fence_t                 fence;       // Fence of the last accepted task
	logic                   stop_r;
	logic [addr_w-1:0]      stop_addr_r;
	logic [load_cnt_w-1:0]  load_cnt;

	logic [num_cores-1:0] busy;
	logic all_idle;
	logic new_idle;
	logic need_all;
	logic ctrl_accept;
	logic streaming;
	logic last_parcel;
	logic disp_raise;
	logic stop_now;

	assign ctrl = task_word.ctrl;
	assign insn = task_word.insn;

	assign busy     = ~cores.ready;
	assign all_idle = busy == '0;
	assign new_idle = (busy & ctrl.core_active) == '0;
	assign need_all = (fence == fence_acq) || (ctrl.fence == fence_rel);

	// A pending stop blocks new control frames until the display is done
	assign ctrl_accept = (frame_cnt == '0) && !stop_r
		&& (all_idle || (!need_all && new_idle));

	assign streaming   = (frame_cnt != '0) && ((busy & active) == '0);
	assign last_parcel = streaming && (load_cnt == load_cnt_w'(parcels_per_frame - 1));
	assign disp_raise  = (frame_cnt == '0) && stop_r && all_idle && !disp_req;
	assign stop_now    = ctrl.stop && (ctrl.insn_frame_num == '0);

	assign cores.start     = streaming ? active : '0;
	assign cores.load_cnt  = load_cnt;
	assign cores.insn_data = insn[load_cnt];

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
		end else if (ctrl_accept) begin
			frame_cnt <= ctrl.insn_frame_num;
		end else if (last_parcel) begin
			frame_cnt <= frame_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= '0;
			fence  <= fence_no;
		end else if (ctrl_accept) begin
			active <= ctrl.core_active;
			fence  <= ctrl.fence;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load_cnt <= '0;
		end else if (last_parcel) begin
			load_cnt <= '0;
		end else if (streaming) begin
			load_cnt <= load_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			task_ptr <= '0;
		end else if (ctrl_accept) begin
			task_ptr <= stop_now ? ctrl.stop_addr : task_ptr + 1'b1;
		end else if (last_parcel) begin
			task_ptr <= task_ptr + 1'b1;
		end else if (disp_req && disp_done) begin
			task_ptr <= stop_addr_r;   // Restart after the display
		end
	end

	// Stop that follows instruction frames goes through the display block
	always_ff @(posedge clk) begin
		if (reset) begin
			stop_r <= 1'b0;
		end else if (ctrl_accept) begin
			stop_r <= ctrl.stop && (ctrl.insn_frame_num != '0);
		end else if (disp_req && disp_done) begin
			stop_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_accept) begin
			stop_addr_r <= ctrl.stop_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			disp_req <= 1'b0;
		end else if (disp_raise) begin
			disp_req <= 1'b1;
		end else if (disp_done) begin
			disp_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cores.init_r0_vect <= '0;
		end else begin
			cores.init_r0_vect <= ctrl_accept ? ctrl.init_r0_vect : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_accept) begin
			cores.init_r0 <= ctrl.init_r0;
		end
	end

endmodule

// ==== hw/task_memory.sv ====
module task_memory #(
	parameter int tm_depth = 16
) (
	input  logic                      clk,
	input  logic                      we,
	input  logic [mcs_pkg::addr_w-1:0] waddr,
	input  mcs_pkg::task_word_u        wdata,
	input  logic [mcs_pkg::addr_w-1:0] raddr,
	output mcs_pkg::task_word_u        rdata
);
	import mcs_pkg::*;

	task_word_u mem [tm_depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Scheduler sees the word at its pointer in the same cycle
	assign rdata = mem[raddr];

endmodule

// ==== hw/core_if.sv ====
interface core_if;
	import mcs_pkg::*;

	logic [num_cores-1:0]            start;
	logic [load_cnt_w-1:0]           load_cnt;
	logic [parcel_w-1:0]             insn_data;
	logic [num_cores-1:0]            init_r0_vect;   // One-cycle load strobe
	logic [num_cores-1:0][reg_w-1:0] init_r0;
	logic [num_cores-1:0]            ready;          // Each core drives its own bit

	modport sched (
		output start,
		output load_cnt,
		output insn_data,
		output init_r0_vect,
		output init_r0,
		input  ready
	);

	modport core (
		input  start,
		input  load_cnt,
		input  insn_data,
		input  init_r0_vect,
		input  init_r0,
		output ready
	);

endinterface

// ==== hw/mcs_pkg.sv ====
package mcs_pkg;

	localparam int num_cores         = 4;
	localparam int parcel_w          = 16;
	localparam int parcels_per_frame = 4;   // Load time of one instruction frame
	localparam int reg_w             = 8;
	localparam int addr_w            = 4;
	localparam int frame_cnt_w       = 4;
	localparam int word_w            = 64;

	localparam int load_cnt_w = $clog2(parcels_per_frame);
	localparam int op_w       = 4;
	localparam int fence_w    = 2;

	localparam int ctrl_used_w = frame_cnt_w + 2 * num_cores + 1 + addr_w + fence_w
		+ num_cores * reg_w;
	localparam int ctrl_pad_w  = word_w - ctrl_used_w;

	typedef enum logic [fence_w-1:0] {
		fence_no  = 2'd0,
		fence_acq = 2'd1,   // Later tasks wait for this one
		fence_rel = 2'd2    // This task waits for earlier ones
	} fence_t;

	// Parcel layout: opcode in the top nibble, 8-bit immediate below it,
	// low nibble spare
	typedef enum logic [op_w-1:0] {
		op_nop = 4'd0,
		op_add = 4'd1,
		op_sub = 4'd2,
		op_xor = 4'd3,
		op_shl = 4'd4
	} opcode_t;

	typedef struct packed {
		logic [ctrl_pad_w-1:0]              pad;
		logic [num_cores-1:0][reg_w-1:0]    init_r0;        // Core 0 in the low byte
		fence_t                             fence;
		logic [addr_w-1:0]                  stop_addr;
		logic                               stop;
		logic [num_cores-1:0]               init_r0_vect;
		logic [num_cores-1:0]               core_active;
		logic [frame_cnt_w-1:0]             insn_frame_num; // Low bits of the word
	} ctrl_frame_t;

	typedef logic [parcels_per_frame-1:0][parcel_w-1:0] insn_frame_t;

	// Meaning depends on the scheduler's frame count
	typedef union packed {
		ctrl_frame_t ctrl;
		insn_frame_t insn;
	} task_word_u;

endpackage
